// File: adc_encoder.sv
/* Turns each ADC comparator word into a signed code and registers it.
   The highest set comparator decides the code, so bubbles below it are ignored. */
`timescale 1ns/100ps

module adc_encoder (
    input  logic                                                      clk,
    input  logic                                                      nrst,
    input  logic [qracc_pkg::OUT_ELEMS-1:0][qracc_pkg::COMP_COUNT-1:0] adc_therm_i,
    output logic signed [qracc_pkg::OUT_ELEMS-1:0][qracc_pkg::ADC_BITS-1:0] adc_code_o
);
    import qracc_pkg::*;

    localparam int CODE_OFFSET = 2 ** (ADC_BITS - 1);   // Midscale, all zeros maps to -8

    logic [OUT_ELEMS-1:0][ADC_BITS-1:0] code_next;

    always_comb begin
        for (int ch = 0; ch < OUT_ELEMS; ch++) begin
            code_next[ch] = ADC_BITS'(-CODE_OFFSET);
            // Later bits overwrite, so the top set comparator wins
            for (int c = 0; c < COMP_COUNT; c++) begin
                if (adc_therm_i[ch][c]) begin
                    code_next[ch] = ADC_BITS'(c + 1 - CODE_OFFSET);
                end
            end
        end
    end

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            adc_code_o <= '0;
        end else begin
            adc_code_o <= code_next;
        end
    end

endmodule

// File: flist.f
qracc_pkg.sv
adc_encoder.sv
switch_matrix_ctrl.sv
sram_phase_timer.sv
sram_access_fsm.sv
qr_acc_wrapper.sv
qr_acc_wrapper_assert.sv
tb_qr_acc_wrapper.sv

// File: qr_acc_wrapper.sv
/* Top level of the digital wrapper around the analog compute macro.
   Joins the ADC encoder, switch-matrix control and SRAM sequencer into one macro drive. */
`timescale 1ns/100ps

module qr_acc_wrapper (
    input  logic                                clk,
    input  logic                                nrst,
    input  qracc_pkg::qracc_config_t            cfg_i,
    input  qracc_pkg::from_analog_t             from_analog_i,
    output qracc_pkg::to_analog_t               to_analog_o,
    output logic signed [qracc_pkg::OUT_ELEMS-1:0][qracc_pkg::ADC_BITS-1:0] adc_out_o,
    input  logic                                mac_en_i,
    input  logic [qracc_pkg::NUM_ROWS-1:0]      data_p_i,
    input  logic [qracc_pkg::NUM_ROWS-1:0]      data_n_i,
    input  logic                                sram_rq_wr_i,
    input  logic                                sram_rq_valid_i,
    input  logic [qracc_pkg::NUM_COLS-1:0]      sram_wr_data_i,
    input  logic [qracc_pkg::ADDR_BITS-1:0]     sram_addr_i,
    output logic                                sram_rq_ready_o,
    output logic                                sram_rd_valid_o,
    output logic [qracc_pkg::NUM_COLS-1:0]      sram_rd_data_o
);
    import qracc_pkg::*;

    matrix_drive_t mdrv;
    sram_drive_t   sdrv;
    logic          wl_start;
    logic          wl_expired;

    adc_encoder u_adc_encoder (
        .clk         (clk),
        .nrst        (nrst),
        .adc_therm_i (from_analog_i.adc_out),
        .adc_code_o  (adc_out_o)
    );

    switch_matrix_ctrl u_switch_matrix_ctrl (
        .clk      (clk),
        .cfg_i    (cfg_i),
        .mac_en_i (mac_en_i),
        .data_p_i (data_p_i),
        .data_n_i (data_n_i),
        .drive_o  (mdrv)
    );

    sram_phase_timer u_sram_phase_timer (
        .clk       (clk),
        .nrst      (nrst),
        .start_i   (wl_start),
        .expired_o (wl_expired)
    );

    sram_access_fsm u_sram_access_fsm (
        .clk             (clk),
        .nrst            (nrst),
        .rq_wr_i         (sram_rq_wr_i),
        .rq_valid_i      (sram_rq_valid_i),
        .wr_data_i       (sram_wr_data_i),
        .addr_i          (sram_addr_i),
        .timer_expired_i (wl_expired),
        .timer_start_o   (wl_start),
        .sa_out_i        (from_analog_i.sa_out),
        .drive_o         (sdrv),
        .rq_ready_o      (sram_rq_ready_o),
        .rd_valid_o      (sram_rd_valid_o),
        .rd_data_o       (sram_rd_data_o)
    );

    // Switch matrices and ADC phases
    assign to_analog_o.psm_vdr_sel    = mdrv.psm_vdr_sel;
    assign to_analog_o.psm_vdr_sel_b  = mdrv.psm_vdr_sel_b;
    assign to_analog_o.psm_vss_sel    = mdrv.psm_vss_sel;
    assign to_analog_o.psm_vss_sel_b  = mdrv.psm_vss_sel_b;
    assign to_analog_o.psm_vrst_sel   = mdrv.psm_vrst_sel;
    assign to_analog_o.psm_vrst_sel_b = mdrv.psm_vrst_sel_b;
    assign to_analog_o.nsm_vdr_sel    = mdrv.nsm_vdr_sel;
    assign to_analog_o.nsm_vdr_sel_b  = mdrv.nsm_vdr_sel_b;
    assign to_analog_o.nsm_vss_sel    = mdrv.nsm_vss_sel;
    assign to_analog_o.nsm_vss_sel_b  = mdrv.nsm_vss_sel_b;
    assign to_analog_o.nsm_vrst_sel   = mdrv.nsm_vrst_sel;
    assign to_analog_o.nsm_vrst_sel_b = mdrv.nsm_vrst_sel_b;
    assign to_analog_o.nf             = mdrv.nf;
    assign to_analog_o.nf_b           = mdrv.nf_b;
    assign to_analog_o.r2a            = mdrv.r2a;
    assign to_analog_o.r2a_b          = mdrv.r2a_b;
    assign to_analog_o.m2a            = mdrv.m2a;
    assign to_analog_o.m2a_b          = mdrv.m2a_b;

    // Weight SRAM
    assign to_analog_o.wl      = sdrv.wl;
    assign to_analog_o.wr_data = sdrv.wr_data;
    assign to_analog_o.write   = sdrv.write;
    assign to_analog_o.csel    = sdrv.csel;
    assign to_analog_o.saen    = sdrv.saen;
    assign to_analog_o.pch     = sdrv.pch;

endmodule

// File: qr_acc_wrapper_assert.sv
/* Protocol assertions for the wrapper's SRAM drive and request interface.
   Bound into every qr_acc_wrapper instance. */
`timescale 1ns/100ps

module qr_acc_wrapper_assert (
    input logic                    clk,
    input logic                    nrst,
    input qracc_pkg::to_analog_t   to_analog_o,
    input logic                    sram_rq_wr_i,
    input logic                    sram_rq_valid_i,
    input logic                    sram_rq_ready_o,
    input logic                    sram_rd_valid_o
);
    import qracc_pkg::*;

    logic rd_pending;   // Read accepted, result not yet out

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            rd_pending <= 1'b0;
        end else if (sram_rq_valid_i && sram_rq_ready_o && !sram_rq_wr_i) begin
            rd_pending <= 1'b1;
        end else if (sram_rd_valid_o) begin
            rd_pending <= 1'b0;
        end
    end

    wl_onehot: assert property (@(posedge clk) disable iff (!nrst) $onehot0(to_analog_o.wl))
        else $error("Wordline is neither idle nor one-hot");

    saen_no_write: assert property (@(posedge clk) disable iff (!nrst)
        !(to_analog_o.saen && to_analog_o.write))
        else $error("Sense enable raised during a write");

    rd_valid_after_read: assert property (@(posedge clk) disable iff (!nrst)
        sram_rd_valid_o |-> rd_pending)
        else $error("Read data valid without an accepted read");

endmodule

bind qr_acc_wrapper qr_acc_wrapper_assert u_assert (
    .clk             (clk),
    .nrst            (nrst),
    .to_analog_o     (to_analog_o),
    .sram_rq_wr_i    (sram_rq_wr_i),
    .sram_rq_valid_i (sram_rq_valid_i),
    .sram_rq_ready_o (sram_rq_ready_o),
    .sram_rd_valid_o (sram_rd_valid_o)
);

// File: qracc_pkg.sv
/* Shared sizes, SRAM phase lengths and analog interface types of the compute macro wrapper.
   Blocks take what they need from here by import. */
package qracc_pkg;

    localparam int NUM_ROWS = 16;            // Array rows, one per input element
    localparam int NUM_COLS = 8;             // SRAM word width
    localparam int OUT_ELEMS = 8;            // ADC channels
    localparam int ADC_BITS = 4;
    localparam int COMP_COUNT = (2 ** ADC_BITS) - 1;
    localparam int ADDR_BITS = 4;
    localparam int WL_CYCLES = 2;            // Wordline phase length in clocks
    localparam int PHASE_CNT_BITS = 4;       // Room for longer SRAM phases

    typedef struct packed {
        logic binary_cfg;                    // 1 selects binary, 0 bipolar
    } qracc_config_t;

    typedef struct packed {
        logic [OUT_ELEMS-1:0][COMP_COUNT-1:0] adc_out;
        logic [NUM_COLS-1:0]                  sa_out;
    } from_analog_t;

    // Switch matrix and ADC phase drive
    typedef struct packed {
        logic [NUM_ROWS-1:0]  psm_vdr_sel;
        logic [NUM_ROWS-1:0]  psm_vdr_sel_b;
        logic [NUM_ROWS-1:0]  psm_vss_sel;
        logic [NUM_ROWS-1:0]  psm_vss_sel_b;
        logic [NUM_ROWS-1:0]  psm_vrst_sel;
        logic [NUM_ROWS-1:0]  psm_vrst_sel_b;
        logic [NUM_ROWS-1:0]  nsm_vdr_sel;
        logic [NUM_ROWS-1:0]  nsm_vdr_sel_b;
        logic [NUM_ROWS-1:0]  nsm_vss_sel;
        logic [NUM_ROWS-1:0]  nsm_vss_sel_b;
        logic [NUM_ROWS-1:0]  nsm_vrst_sel;
        logic [NUM_ROWS-1:0]  nsm_vrst_sel_b;
        logic [OUT_ELEMS-1:0] nf;
        logic [OUT_ELEMS-1:0] nf_b;
        logic [OUT_ELEMS-1:0] r2a;
        logic [OUT_ELEMS-1:0] r2a_b;
        logic [OUT_ELEMS-1:0] m2a;
        logic [OUT_ELEMS-1:0] m2a_b;
    } matrix_drive_t;

    // Weight SRAM drive
    typedef struct packed {
        logic [NUM_ROWS-1:0] wl;
        logic [NUM_COLS-1:0] wr_data;
        logic                write;
        logic                csel;
        logic                saen;
        logic                pch;            // Active-low precharge
    } sram_drive_t;

    // Complete drive into the macro
    typedef struct packed {
        logic [NUM_ROWS-1:0]  psm_vdr_sel;
        logic [NUM_ROWS-1:0]  psm_vdr_sel_b;
        logic [NUM_ROWS-1:0]  psm_vss_sel;
        logic [NUM_ROWS-1:0]  psm_vss_sel_b;
        logic [NUM_ROWS-1:0]  psm_vrst_sel;
        logic [NUM_ROWS-1:0]  psm_vrst_sel_b;
        logic [NUM_ROWS-1:0]  nsm_vdr_sel;
        logic [NUM_ROWS-1:0]  nsm_vdr_sel_b;
        logic [NUM_ROWS-1:0]  nsm_vss_sel;
        logic [NUM_ROWS-1:0]  nsm_vss_sel_b;
        logic [NUM_ROWS-1:0]  nsm_vrst_sel;
        logic [NUM_ROWS-1:0]  nsm_vrst_sel_b;
        logic [OUT_ELEMS-1:0] nf;
        logic [OUT_ELEMS-1:0] nf_b;
        logic [OUT_ELEMS-1:0] r2a;
        logic [OUT_ELEMS-1:0] r2a_b;
        logic [OUT_ELEMS-1:0] m2a;
        logic [OUT_ELEMS-1:0] m2a_b;
        logic [NUM_ROWS-1:0]  wl;
        logic [NUM_COLS-1:0]  wr_data;
        logic                 write;
        logic                 csel;
        logic                 saen;
        logic                 pch;
    } to_analog_t;

    typedef enum logic [2:0] {
        IDLE,
        PRECH,
        WLINE,
        SENSE,
        DONE
    } sram_state_e;

endpackage

// File: run.sh
#!/bin/sh
# Build and run the wrapper testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_qr_acc_wrapper -f flist.f -o sim_tb

./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "Simulation finished: PASS" sim.log; then
    exit 0
else
    exit 1
fi

// File: sram_access_fsm.sv
/* Sequences single-row weight SRAM reads and writes through precharge, wordline and sense.
   One request at a time, ready stays low until the access has finished. */
`timescale 1ns/100ps

module sram_access_fsm (
    input  logic                              clk,
    input  logic                              nrst,
    input  logic                              rq_wr_i,
    input  logic                              rq_valid_i,
    input  logic [qracc_pkg::NUM_COLS-1:0]    wr_data_i,
    input  logic [qracc_pkg::ADDR_BITS-1:0]   addr_i,
    input  logic                              timer_expired_i,
    output logic                              timer_start_o,
    input  logic [qracc_pkg::NUM_COLS-1:0]    sa_out_i,
    output qracc_pkg::sram_drive_t            drive_o,
    output logic                              rq_ready_o,
    output logic                              rd_valid_o,
    output logic [qracc_pkg::NUM_COLS-1:0]    rd_data_o
);
    import qracc_pkg::*;

    sram_state_e          state_q, state_d;
    logic                 accept;
    logic                 is_wr_q;
    logic [ADDR_BITS-1:0] addr_q;
    logic [NUM_COLS-1:0]  wr_data_q;

    assign rq_ready_o    = (state_q == IDLE);
    assign accept        = rq_valid_i && rq_ready_o;
    assign timer_start_o = (state_q == PRECH);   // Loads timer for WLINE

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE:    if (accept) state_d = PRECH;
            PRECH:   state_d = WLINE;
            WLINE:   if (timer_expired_i) state_d = SENSE;
            SENSE:   state_d = DONE;
            DONE:    state_d = IDLE;
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            state_q    <= IDLE;
            is_wr_q    <= 1'b0;
            rd_valid_o <= 1'b0;
        end else begin
            state_q    <= state_d;
            rd_valid_o <= (state_q == DONE) && !is_wr_q;
            if (accept) begin
                is_wr_q <= rq_wr_i;
            end
        end
    end

    // Request payload and read capture
    always_ff @(posedge clk) begin
        if (accept) begin
            addr_q    <= addr_i;
            wr_data_q <= wr_data_i;
        end
        if (state_q == DONE && !is_wr_q) begin
            rd_data_o <= sa_out_i;   // Macro holds sa_out through DONE
        end
    end

    always_comb begin
        drive_o         = '0;
        drive_o.wr_data = wr_data_q;
        drive_o.csel    = (state_q != IDLE);
        drive_o.pch     = (state_q != PRECH);
        drive_o.saen    = (state_q == SENSE) && !is_wr_q;
        if (state_q == WLINE) begin
            drive_o.wl[addr_q] = 1'b1;
            drive_o.write      = is_wr_q;
        end
    end

endmodule

// File: sram_phase_timer.sv
/* Down counter that times an SRAM phase, loaded by a start strobe.
   expired_o marks the last cycle of the timed phase. */
`timescale 1ns/100ps

module sram_phase_timer (
    input  logic clk,
    input  logic nrst,
    input  logic start_i,
    output logic expired_o
);
    import qracc_pkg::*;

    logic [PHASE_CNT_BITS-1:0] count_q;
    logic                      running_q;

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            count_q   <= '0;
            running_q <= 1'b0;
        end else if (start_i) begin
            count_q   <= PHASE_CNT_BITS'(WL_CYCLES - 1);
            running_q <= 1'b1;
        end else if (running_q) begin
            if (count_q == '0) begin
                running_q <= 1'b0;                // Phase over
            end else begin
                count_q <= count_q - 1'b1;
            end
        end
    end

    assign expired_o = running_q && (count_q == '0);

endmodule

// File: switch_matrix_ctrl.sv
/* Combinational switch-matrix selects and ADC phase controls for the MAC array.
   High half of clk with MAC enabled is the reset phase, low half evaluates. */
`timescale 1ns/100ps

module switch_matrix_ctrl (
    input  logic                              clk,
    input  qracc_pkg::qracc_config_t          cfg_i,
    input  logic                              mac_en_i,
    input  logic [qracc_pkg::NUM_ROWS-1:0]    data_p_i,
    input  logic [qracc_pkg::NUM_ROWS-1:0]    data_n_i,
    output qracc_pkg::matrix_drive_t          drive_o
);
    import qracc_pkg::*;

    logic                rst_phase;
    logic [NUM_ROWS-1:0] rst_mask;
    logic [NUM_ROWS-1:0] pos_rows;      // +1 inputs
    logic [NUM_ROWS-1:0] neg_rows;      // -1 inputs
    logic [NUM_ROWS-1:0] zero_rows;

    assign rst_phase = clk & mac_en_i;
    assign rst_mask  = {NUM_ROWS{rst_phase}};
    assign pos_rows  = data_p_i & ~data_n_i;
    assign neg_rows  = data_n_i & ~data_p_i;
    assign zero_rows = ~data_p_i & ~data_n_i;

    always_comb begin
        // PSM follows input polarity directly
        drive_o.psm_vdr_sel  = pos_rows & ~rst_mask;
        drive_o.psm_vss_sel  = neg_rows & ~rst_mask;
        drive_o.psm_vrst_sel = zero_rows | rst_mask;

        if (cfg_i.binary_cfg) begin
            drive_o.nsm_vdr_sel  = '0;                // NSM parked on vrst
            drive_o.nsm_vss_sel  = '0;
            drive_o.nsm_vrst_sel = '1;
        end else begin
            drive_o.nsm_vdr_sel  = neg_rows & ~rst_mask;   // Swapped polarity
            drive_o.nsm_vss_sel  = pos_rows & ~rst_mask;
            drive_o.nsm_vrst_sel = zero_rows | rst_mask;
        end

        drive_o.psm_vdr_sel_b  = ~drive_o.psm_vdr_sel;
        drive_o.psm_vss_sel_b  = ~drive_o.psm_vss_sel;
        drive_o.psm_vrst_sel_b = ~drive_o.psm_vrst_sel;
        drive_o.nsm_vdr_sel_b  = ~drive_o.nsm_vdr_sel;
        drive_o.nsm_vss_sel_b  = ~drive_o.nsm_vss_sel;
        drive_o.nsm_vrst_sel_b = ~drive_o.nsm_vrst_sel;

        // Negative feedback only during the reset phase, it draws power
        drive_o.nf    = {OUT_ELEMS{rst_phase}};
        drive_o.r2a   = {OUT_ELEMS{rst_phase}};
        drive_o.m2a   = {OUT_ELEMS{~rst_phase}};
        drive_o.nf_b  = ~drive_o.nf;
        drive_o.r2a_b = ~drive_o.r2a;
        drive_o.m2a_b = ~drive_o.m2a;
    end

endmodule

// File: tb_qr_acc_wrapper.sv
/* Testbench for the compute macro wrapper, with a behavioral macro and a reference model.
   Random stimulus from a fixed seed covers switch matrices, ADC encoding and SRAM access. */
`timescale 1ns/100ps

module tb_qr_acc_wrapper;
    import qracc_pkg::*;

    localparam int CLK_HALF = 10;
    localparam int DRV_DELAY = 2;
    localparam int TIMEOUT_CYC = 40;
    localparam int ADC_MID = 8;              // Code of an all-zero comparator word is -8

    logic clk;
    logic nrst;
    qracc_config_t cfg;
    logic [OUT_ELEMS-1:0][COMP_COUNT-1:0] adc_therm;
    logic [NUM_COLS-1:0] sa_out;
    from_analog_t from_analog;
    to_analog_t to_analog;
    logic signed [OUT_ELEMS-1:0][ADC_BITS-1:0] adc_out;
    logic mac_en;
    logic [NUM_ROWS-1:0] data_p;
    logic [NUM_ROWS-1:0] data_n;
    logic rq_wr;
    logic rq_valid;
    logic [NUM_COLS-1:0] wr_data;
    logic [ADDR_BITS-1:0] addr;
    logic rq_ready;
    logic rd_valid;
    logic [NUM_COLS-1:0] rd_data;

    integer seed;
    logic [NUM_COLS-1:0] macro_mem [NUM_ROWS];   // Bitcells of the macro model
    logic [NUM_COLS-1:0] ref_mem [NUM_ROWS];     // Expected array contents
    logic [ADDR_BITS-1:0] sel_row;

    assign from_analog = {adc_therm, sa_out};

    qr_acc_wrapper u_dut (
        .clk             (clk),
        .nrst            (nrst),
        .cfg_i           (cfg),
        .from_analog_i   (from_analog),
        .to_analog_o     (to_analog),
        .adc_out_o       (adc_out),
        .mac_en_i        (mac_en),
        .data_p_i        (data_p),
        .data_n_i        (data_n),
        .sram_rq_wr_i    (rq_wr),
        .sram_rq_valid_i (rq_valid),
        .sram_wr_data_i  (wr_data),
        .sram_addr_i     (addr),
        .sram_rq_ready_o (rq_ready),
        .sram_rd_valid_o (rd_valid),
        .sram_rd_data_o  (rd_data)
    );

    initial begin
        clk = 1'b0;
        forever #CLK_HALF clk = ~clk;
    end

    function automatic logic [NUM_COLS-1:0] fill_word(int r);
        return {ADDR_BITS'(r), ~ADDR_BITS'(r)};   // Power-up pattern per row
    endfunction

    function automatic logic [31:0] rand_word();
        logic [31:0] r;
        r = $random(seed);
        return r;
    endfunction

    function automatic logic coin_flip();
        logic [31:0] r;
        r = $random(seed);
        return r[0];
    endfunction

    function automatic logic [COMP_COUNT-1:0] therm_word(int n);
        logic [COMP_COUNT-1:0] w;
        w = '0;
        for (int i = 0; i < n; i++) begin
            w[i] = 1'b1;
        end
        return w;
    endfunction

    // Scan down from the top comparator
    function automatic logic [ADC_BITS-1:0] top_bit_code(logic [COMP_COUNT-1:0] w);
        int top;
        top = -1;
        for (int i = COMP_COUNT - 1; i >= 0; i--) begin
            if (w[i] && top < 0) top = i;
        end
        return ADC_BITS'(top + 1 - ADC_MID);
    endfunction

    task automatic compare_value(input string name, input logic [63:0] expected,
                                 input logic [63:0] actual);
        if (expected !== actual) begin
            $display("ERR %s: expected %0h actual %0h", name, expected, actual);
            $display("Simulation finished: FAIL");
            $fatal(1, "Mismatch in %s", name);
        end
    endtask

    task automatic timeout_abort(input string what);
        $display("Timed out while waiting for %s", what);
        $display("Simulation finished: FAIL");
        $fatal(1, "Timeout");
    endtask

    // Behavioral macro: SRAM bitcells and sense amplifiers
    always @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            for (int r = 0; r < NUM_ROWS; r++) macro_mem[r] <= fill_word(r);
            sel_row <= '0;
        end else begin
            for (int r = 0; r < NUM_ROWS; r++) begin
                if (to_analog.wl[r]) begin
                    sel_row <= ADDR_BITS'(r);
                    if (to_analog.write) macro_mem[r] <= to_analog.wr_data;
                end
            end
        end
    end

    always @(negedge clk or negedge nrst) begin
        if (!nrst) begin
            sa_out <= '0;
        end else if (to_analog.saen) begin
            sa_out <= macro_mem[sel_row];   // Held until next sense
        end
    end

    task automatic reset_state_check();
        compare_value("reset ready", 1, rq_ready);
        compare_value("reset rd_valid", 0, rd_valid);
        compare_value("reset write", 0, to_analog.write);
        compare_value("reset saen", 0, to_analog.saen);
        compare_value("reset csel", 0, to_analog.csel);
        compare_value("reset wl", 0, to_analog.wl);
        compare_value("reset pch", 1, to_analog.pch);
        compare_value("reset adc_out", 0, {adc_out});
    endtask

    task automatic switch_matrix_test();
        logic [NUM_ROWS-1:0] pos;
        logic [NUM_ROWS-1:0] neg;
        logic [NUM_ROWS-1:0] zero;
        logic [NUM_ROWS-1:0] nsm_vdr;
        logic [NUM_ROWS-1:0] nsm_vss;
        logic [NUM_ROWS-1:0] nsm_vrst;
        for (int i = 0; i < 48; i++) begin
            @(posedge clk);
            #DRV_DELAY;
            cfg.binary_cfg = coin_flip();
            mac_en = coin_flip();
            data_p = NUM_ROWS'(rand_word());
            data_n = NUM_ROWS'(rand_word());
            pos  = data_p & ~data_n;
            neg  = data_n & ~data_p;
            zero = ~data_p & ~data_n;
            nsm_vdr  = cfg.binary_cfg ? '0 : neg;      // Binary mode parks the NSM on vrst
            nsm_vss  = cfg.binary_cfg ? '0 : pos;
            nsm_vrst = cfg.binary_cfg ? '1 : zero;
            #3;                                    // High clock phase
            if (mac_en) begin
                compare_value("rst psm_vrst", {NUM_ROWS{1'b1}}, to_analog.psm_vrst_sel);
                compare_value("rst nsm_vrst", {NUM_ROWS{1'b1}}, to_analog.nsm_vrst_sel);
                compare_value("rst psm_vdr", 0, to_analog.psm_vdr_sel | to_analog.psm_vss_sel);
                compare_value("rst nsm_vdr", 0, to_analog.nsm_vdr_sel | to_analog.nsm_vss_sel);
                compare_value("rst nf", {OUT_ELEMS{1'b1}}, to_analog.nf);
                compare_value("rst r2a", {OUT_ELEMS{1'b1}}, to_analog.r2a);
                compare_value("rst m2a", 0, to_analog.m2a);
                compare_value("rst nf_b r2a_b", 0, to_analog.nf_b | to_analog.r2a_b);
                compare_value("rst m2a_b", {OUT_ELEMS{1'b1}}, to_analog.m2a_b);
            end else begin
                compare_value("idle high m2a", {OUT_ELEMS{1'b1}}, to_analog.m2a);
                compare_value("idle high nf", 0, to_analog.nf | to_analog.r2a);
            end
            #10;                                   // Low clock phase
            compare_value("psm_vdr", pos, to_analog.psm_vdr_sel);
            compare_value("psm_vss", neg, to_analog.psm_vss_sel);
            compare_value("psm_vrst", zero, to_analog.psm_vrst_sel);
            compare_value("nsm_vdr", nsm_vdr, to_analog.nsm_vdr_sel);
            compare_value("nsm_vss", nsm_vss, to_analog.nsm_vss_sel);
            compare_value("nsm_vrst", nsm_vrst, to_analog.nsm_vrst_sel);
            compare_value("psm_vdr_b", NUM_ROWS'(~pos), to_analog.psm_vdr_sel_b);
            compare_value("psm_vss_b", NUM_ROWS'(~neg), to_analog.psm_vss_sel_b);
            compare_value("psm_vrst_b", NUM_ROWS'(~zero), to_analog.psm_vrst_sel_b);
            compare_value("nsm_vdr_b", NUM_ROWS'(~nsm_vdr), to_analog.nsm_vdr_sel_b);
            compare_value("nsm_vss_b", NUM_ROWS'(~nsm_vss), to_analog.nsm_vss_sel_b);
            compare_value("nsm_vrst_b", NUM_ROWS'(~nsm_vrst), to_analog.nsm_vrst_sel_b);
            compare_value("low m2a", {OUT_ELEMS{1'b1}}, to_analog.m2a);
            compare_value("low m2a_b", 0, to_analog.m2a_b);
            compare_value("low nf r2a", 0, to_analog.nf | to_analog.r2a);
            compare_value("low nf_b r2a_b", {OUT_ELEMS{1'b1}}, to_analog.nf_b & to_analog.r2a_b);
        end
        @(posedge clk);
        #DRV_DELAY;
        mac_en = 1'b0;
    endtask

    task automatic adc_code_test();
        int cnt;
        logic [ADC_BITS-1:0] exp_code [OUT_ELEMS];
        @(posedge clk);
        #DRV_DELAY;
        for (int i = 0; i < 32; i++) begin
            for (int ch = 0; ch < OUT_ELEMS; ch++) begin
                if (i < 16) begin
                    cnt = int'(rand_word() % 16);
                    adc_therm[ch] = therm_word(cnt);
                    exp_code[ch] = ADC_BITS'(cnt - ADC_MID);
                end else begin
                    adc_therm[ch] = COMP_COUNT'(rand_word());   // Bubbles allowed
                    exp_code[ch] = top_bit_code(adc_therm[ch]);
                end
            end
            @(posedge clk);
            #DRV_DELAY;
            for (int ch = 0; ch < OUT_ELEMS; ch++) begin
                compare_value($sformatf("adc code ch%0d", ch), exp_code[ch], adc_out[ch]);
            end
        end
    endtask

    task automatic sram_access(input logic wr, input logic [ADDR_BITS-1:0] a,
                               input logic [NUM_COLS-1:0] d);
        int waited;
        waited = 0;
        while (!rq_ready) begin
            @(posedge clk);
            #DRV_DELAY;
            waited++;
            if (waited > TIMEOUT_CYC) timeout_abort("SRAM ready before a request");
        end
        rq_valid = 1'b1;
        rq_wr    = wr;
        addr     = a;
        wr_data  = d;
        @(posedge clk);
        #DRV_DELAY;
        compare_value("ready low after accept", 0, rq_ready);
        compare_value("precharge pch", 0, to_analog.pch);
        compare_value("precharge csel", 1, to_analog.csel);
        if (wr) ref_mem[a] = d;
        // Stray write while busy must be dropped
        rq_wr   = 1'b1;
        addr    = ADDR_BITS'(rand_word());
        wr_data = NUM_COLS'(rand_word());
        @(posedge clk);
        #DRV_DELAY;
        compare_value("ready low while busy", 0, rq_ready);
        compare_value("wordline", NUM_ROWS'(1) << a, to_analog.wl);
        compare_value("wordline write", wr, to_analog.write);
        if (wr) compare_value("wordline data", d, to_analog.wr_data);
        rq_valid = 1'b0;
        rq_wr    = 1'b0;
        waited = 0;
        while (!rq_ready) begin
            compare_value("rd_valid during access", 0, rd_valid);
            @(posedge clk);
            #DRV_DELAY;
            waited++;
            if (waited > TIMEOUT_CYC) timeout_abort("end of SRAM access");
        end
        if (wr) begin
            compare_value("rd_valid after write", 0, rd_valid);
        end else begin
            compare_value("rd_valid after read", 1, rd_valid);
            compare_value($sformatf("read row %0d", a), ref_mem[a], rd_data);
        end
    endtask

    task automatic sram_rw_test();
        for (int i = 0; i < 12; i++) begin
            sram_access(1'b1, ADDR_BITS'(rand_word()), NUM_COLS'(rand_word()));
        end
        for (int i = 0; i < 16; i++) begin
            sram_access(1'b0, ADDR_BITS'(rand_word()), '0);
        end
    endtask

    initial begin
        seed      = 32'h3931_6658;
        nrst      = 1'b0;
        cfg       = '0;
        mac_en    = 1'b0;
        data_p    = '0;
        data_n    = '0;
        adc_therm = '0;
        rq_wr     = 1'b0;
        rq_valid  = 1'b0;
        wr_data   = '0;
        addr      = '0;
        for (int r = 0; r < NUM_ROWS; r++) ref_mem[r] = fill_word(r);
        repeat (2) @(posedge clk);
        #DRV_DELAY;
        reset_state_check();
        nrst = 1'b1;
        switch_matrix_test();
        adc_code_test();
        sram_rw_test();
        $display("Simulation finished: PASS");
        $finish;
    end

endmodule
